//--- include/idiv_config.svh
// ======================================
// width settings for the iterative divider
// included by the package and by every module that sizes logic from them
// ======================================
`ifndef IDIV_CONFIG_SVH
`define IDIV_CONFIG_SVH

// operand width in bits, any even width works
`define IDIV_WIDTH 32

// one quotient bit per iteration
`define IDIV_ITERS `IDIV_WIDTH

// counter must reach IDIV_ITERS itself
`define IDIV_CNT_W $clog2(`IDIV_ITERS + 1)

`endif

//--- verilog/idiv_pkg.sv
// ======================================
// shared types of the iterative divider
// request and response payloads, the controller to datapath
// bundles and the FSM state encoding
// ======================================
`include "idiv_config.svh"

package idiv_pkg;

    // request taken on v_i / ready_and_o
    typedef struct packed {
        logic [`IDIV_WIDTH-1:0] dividend;
        logic [`IDIV_WIDTH-1:0] divisor;
        logic                   is_signed;
    } div_req_t;

    // result offered on v_o / yumi_i
    typedef struct packed {
        logic [`IDIV_WIDTH-1:0] quotient;
        logic [`IDIV_WIDTH-1:0] remainder;
    } div_resp_t;

    // selects are one-hot: [2] load, [1] adder sum, [0] shift
    typedef struct packed {
        logic       opa_sel;
        logic       opa_ld;
        logic       opa_inv;
        logic       opa_clr_l;
        logic [2:0] opb_sel;
        logic       opb_ld;
        logic       opb_inv;
        logic       opb_clr_l;
        logic [2:0] opc_sel;
        logic       opc_ld;
        logic       latch_signed;
        logic       adder_cin;
    } idiv_ctrl_t;

    // raw flags, all decisions are made in the controller
    typedef struct packed {
        logic zero_divisor;
        logic signed_div_r;
        logic adder_neg;
        logic opa_neg;
        logic opc_neg;
    } idiv_status_t;

    typedef enum logic [3:0] {
        WAIT,
        NEG0,
        NEG1,
        SHIFT,
        CALC,
        REPAIR,
        REMAIN,
        QUOT,
        DONE
    } idiv_state_e;

endpackage

//--- verilog/idiv_controller.sv
// ======================================
// FSM of the iterative divider
// sequences sign correction, the non-restoring iterations,
// remainder repair and the result handshake
// ======================================
`timescale 1ns/1ps
`include "idiv_config.svh"

module idiv_controller
    import idiv_pkg::*;
(
    input  logic         clk_i,
    input  logic         reset_i,
    input  logic         v_i,
    output logic         ready_and_o,
    input  idiv_status_t status_i,
    output idiv_ctrl_t   ctrl_o,
    output logic         v_o,
    input  logic         yumi_i
);

    localparam int unsigned cnt_w = `IDIV_CNT_W;
    localparam logic [cnt_w-1:0] calc_last = cnt_w'(`IDIV_ITERS);

    idiv_state_e      state_r;
    idiv_state_e      state_n;
    logic [cnt_w-1:0] calc_cnt_r;
    logic             calc_done;
    logic             add_neg_last_r;
    logic             q_neg_r;
    logic             r_neg_r;
    logic             neg_ld;
    logic             go_quot;

    // CALC runs IDIV_ITERS + 1 cycles, counter values 0 .. IDIV_ITERS
    assign calc_done = (calc_cnt_r == calc_last);

    // a zero divisor keeps the all-ones quotient unnegated
    assign go_quot = q_neg_r & ~status_i.zero_divisor;

    // ======================================
    // state and sign bookkeeping
    // ======================================
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r        <= WAIT;
            calc_cnt_r     <= '0;
            add_neg_last_r <= 1'b0;
            q_neg_r        <= 1'b0;
            r_neg_r        <= 1'b0;
        end else begin
            state_r        <= state_n;
            add_neg_last_r <= status_i.adder_neg;

            if ((state_r == CALC) && !calc_done) begin
                calc_cnt_r <= calc_cnt_r + 1'b1;
            end else begin
                calc_cnt_r <= '0;
            end

            // operands still carry their original signs in NEG0
            if (neg_ld) begin
                q_neg_r <= (status_i.opa_neg ^ status_i.opc_neg) & status_i.signed_div_r;
                r_neg_r <= status_i.opc_neg & status_i.signed_div_r;
            end
        end
    end

    // ======================================
    // next state and datapath control
    // ======================================
    always_comb begin
        ctrl_o              = '0;
        ctrl_o.opa_clr_l    = 1'b1;
        ctrl_o.opb_clr_l    = 1'b1;
        ctrl_o.opb_sel      = 3'b001;
        ctrl_o.opc_sel      = 3'b001;
        neg_ld              = 1'b0;
        state_n             = state_r;

        case (state_r)
            WAIT: begin
                ctrl_o.opa_sel = 1'b1;
                ctrl_o.opc_sel = 3'b100;
                if (v_i) begin
                    ctrl_o.opa_ld       = 1'b1;
                    ctrl_o.opc_ld       = 1'b1;
                    ctrl_o.latch_signed = 1'b1;
                    state_n             = NEG0;
                end
            end
            NEG0: begin
                // sum = -opA, kept only for a negative signed divisor
                ctrl_o.opa_inv   = 1'b1;
                ctrl_o.opb_clr_l = 1'b0;
                ctrl_o.adder_cin = 1'b1;
                ctrl_o.opa_ld    = status_i.opa_neg & status_i.signed_div_r;
                // copy the dividend into opB for a possible negation
                ctrl_o.opb_sel   = 3'b100;
                ctrl_o.opb_ld    = 1'b1;
                neg_ld           = 1'b1;
                state_n = (status_i.opc_neg & status_i.signed_div_r) ? NEG1 : SHIFT;
            end
            NEG1: begin
                ctrl_o.opa_clr_l = 1'b0;
                ctrl_o.opb_inv   = 1'b1;
                ctrl_o.adder_cin = 1'b1;
                ctrl_o.opc_sel   = 3'b010;
                ctrl_o.opc_ld    = 1'b1;
                state_n          = SHIFT;
            end
            SHIFT: begin
                // adder gives zero, opB starts empty
                ctrl_o.opa_clr_l = 1'b0;
                ctrl_o.opb_clr_l = 1'b0;
                ctrl_o.opb_ld    = 1'b1;
                ctrl_o.opc_ld    = 1'b1;
                state_n          = CALC;
            end
            CALC: begin
                // subtract after a non-negative result, add after a negative one
                ctrl_o.opa_inv   = ~add_neg_last_r;
                ctrl_o.adder_cin = ~add_neg_last_r;
                ctrl_o.opb_sel   = calc_done ? 3'b010 : 3'b001;
                ctrl_o.opb_ld    = 1'b1;
                ctrl_o.opc_ld    = 1'b1;
                if (calc_done) begin
                    state_n = status_i.adder_neg ? REPAIR : REMAIN;
                end
            end
            REPAIR: begin
                ctrl_o.opb_sel = 3'b010;
                ctrl_o.opb_ld  = 1'b1;
                state_n        = REMAIN;
            end
            REMAIN: begin
                ctrl_o.opa_clr_l = 1'b0;
                ctrl_o.opb_inv   = r_neg_r;
                ctrl_o.adder_cin = r_neg_r;
                if (go_quot) begin
                    // park the fixed remainder in opC, quotient moves to opB
                    ctrl_o.opc_sel = 3'b010;
                    ctrl_o.opc_ld  = 1'b1;
                    ctrl_o.opb_sel = 3'b100;
                    ctrl_o.opb_ld  = 1'b1;
                    state_n        = QUOT;
                end else begin
                    ctrl_o.opb_sel = 3'b010;
                    ctrl_o.opb_ld  = 1'b1;
                    state_n        = DONE;
                end
            end
            QUOT: begin
                // swap back while negating, opC gets -quotient, opB the remainder
                ctrl_o.opa_clr_l = 1'b0;
                ctrl_o.opb_inv   = 1'b1;
                ctrl_o.adder_cin = 1'b1;
                ctrl_o.opc_sel   = 3'b010;
                ctrl_o.opc_ld    = 1'b1;
                ctrl_o.opb_sel   = 3'b100;
                ctrl_o.opb_ld    = 1'b1;
                state_n          = DONE;
            end
            DONE: begin
                if (yumi_i) begin
                    state_n = WAIT;
                end
            end
            default: begin
                state_n = WAIT;
            end
        endcase
    end

    assign ready_and_o = (state_r == WAIT);
    assign v_o         = (state_r == DONE);

endmodule

//--- verilog/idiv_datapath.sv
// ======================================
// datapath of the iterative divider
// three operand registers one bit wider than the operands,
// one shared inverting adder, raw flags for the controller
// ======================================
`timescale 1ns/1ps
`include "idiv_config.svh"

module idiv_datapath
    import idiv_pkg::*;
(
    input  logic         clk_i,
    input  div_req_t     req_i,
    input  idiv_ctrl_t   ctrl_i,
    output idiv_status_t status_o,
    output div_resp_t    resp_o
);

    localparam int unsigned w = `IDIV_WIDTH;

    // opA divisor, opB partial remainder, opC dividend then quotient
    logic [w:0] opa_r;
    logic [w:0] opb_r;
    logic [w:0] opc_r;
    logic [w:0] opa_n;
    logic [w:0] opb_n;
    logic [w:0] opc_n;
    logic [w:0] divisor_ext;
    logic [w:0] dividend_ext;
    logic [w:0] add_a;
    logic [w:0] add_b;
    logic [w:0] sum;
    logic       signed_div_r;

    // extend by one bit so that the most negative value negates cleanly
    assign divisor_ext  = {req_i.is_signed & req_i.divisor[w-1], req_i.divisor};
    assign dividend_ext = {req_i.is_signed & req_i.dividend[w-1], req_i.dividend};

    // ======================================
    // shared adder
    // ======================================
    assign add_a = (opa_r ^ {(w+1){ctrl_i.opa_inv}}) & {(w+1){ctrl_i.opa_clr_l}};
    assign add_b = (opb_r ^ {(w+1){ctrl_i.opb_inv}}) & {(w+1){ctrl_i.opb_clr_l}};
    assign sum   = add_a + add_b + {{w{1'b0}}, ctrl_i.adder_cin};

    // ======================================
    // register input selects
    // ======================================
    assign opa_n = ctrl_i.opa_sel ? divisor_ext : sum;

    // shift brings in the next dividend bit from the top of opC
    assign opb_n = ({(w+1){ctrl_i.opb_sel[2]}} & opc_r)
                 | ({(w+1){ctrl_i.opb_sel[1]}} & sum)
                 | ({(w+1){ctrl_i.opb_sel[0]}} & {sum[w-1:0], opc_r[w]});

    // quotient bit is set when the new partial remainder is non-negative
    assign opc_n = ({(w+1){ctrl_i.opc_sel[2]}} & dividend_ext)
                 | ({(w+1){ctrl_i.opc_sel[1]}} & sum)
                 | ({(w+1){ctrl_i.opc_sel[0]}} & {opc_r[w-1:0], ~sum[w]});

    always_ff @(posedge clk_i) begin
        if (ctrl_i.opa_ld) begin
            opa_r <= opa_n;
        end
        if (ctrl_i.opb_ld) begin
            opb_r <= opb_n;
        end
        if (ctrl_i.opc_ld) begin
            opc_r <= opc_n;
        end
        if (ctrl_i.latch_signed) begin
            signed_div_r <= req_i.is_signed;
        end
    end

    // ======================================
    // flags and result
    // ======================================
    assign status_o.zero_divisor = ~|opa_r;
    assign status_o.signed_div_r = signed_div_r;
    assign status_o.adder_neg    = sum[w];
    assign status_o.opa_neg      = opa_r[w];
    assign status_o.opc_neg      = opc_r[w];

    assign resp_o.quotient  = opc_r[w-1:0];
    assign resp_o.remainder = opb_r[w-1:0];

endmodule

//--- verilog/idiv_top.sv
// ======================================
// iterative integer divider, top level
// requests on v_i / ready_and_o, results on v_o / yumi_i
// ======================================
`timescale 1ns/1ps

module idiv_top
    import idiv_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      v_i,
    input  div_req_t  req_i,
    output logic      ready_and_o,
    output logic      v_o,
    output div_resp_t resp_o,
    input  logic      yumi_i
);

    idiv_ctrl_t   ctrl;
    idiv_status_t status;

    idiv_controller u_controller (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .v_i         (v_i),
        .ready_and_o (ready_and_o),
        .status_i    (status),
        .ctrl_o      (ctrl),
        .v_o         (v_o),
        .yumi_i      (yumi_i)
    );

    // result registers drive resp_o with no extra stage
    idiv_datapath u_datapath (
        .clk_i    (clk_i),
        .req_i    (req_i),
        .ctrl_i   (ctrl),
        .status_o (status),
        .resp_o   (resp_o)
    );

endmodule

//--- testbench/idiv_assertions.sv
// ========================================
// concurrent checks on the divider FSM and its handshake,
// bound into idiv_controller from the testbench
// ========================================
`timescale 1ns/1ps

module idiv_assertions
    import idiv_pkg::*;
(
    input logic        clk_i,
    input logic        reset_i,
    input logic        ready_i,
    input logic        valid_i,
    input logic        yumi_i,
    input idiv_state_e state_i,
    input idiv_ctrl_t  ctrl_i
);

    a_no_overlap: assert property (@(posedge clk_i) disable iff (reset_i)
        !(ready_i && valid_i))
        else $error("ready_and_o and v_o high in the same cycle");

    a_done_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        (state_i == DONE) |-> valid_i)
        else $error("state DONE without v_o");

    // resp_o comes straight from opB and opC, no load keeps it steady
    a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        (valid_i && !yumi_i) |-> !(ctrl_i.opb_ld || ctrl_i.opc_ld))
        else $error("result registers loaded while the result waits");

    a_back_to_wait: assert property (@(posedge clk_i) disable iff (reset_i)
        (valid_i && yumi_i) |=> (state_i == WAIT))
        else $error("FSM did not return to WAIT after yumi_i");

endmodule

//--- testbench/idiv_tb.sv
// ========================================
// testbench for the iterative divider
// runs a table of fixed and random requests through idiv_top and
// checks results, latency and the hold under back-pressure
// ========================================
`timescale 1ns/1ps
`include "idiv_config.svh"

module idiv_tb
    import idiv_pkg::*;
();

    localparam int w            = `IDIV_WIDTH;
    localparam int n_fixed      = 12;
    localparam int n_rows       = 20;
    localparam int max_delay    = 3;
    localparam int reset_cycles = 3;
    localparam int cycle_limit  = n_rows * (`IDIV_ITERS + 8 + max_delay + 4) + reset_cycles;
    localparam logic [w-1:0] min_v = {1'b1, {(w-1){1'b0}}};
    localparam logic [w-1:0] ones  = '1;
    // all ones divided by three, exact for even widths
    localparam logic [w-1:0] third = {(w/2){2'b01}};

    typedef struct packed {
        div_req_t   req;
        logic [1:0] delay;
        div_resp_t  exp;
    } row_t;

    logic        clk_i;
    logic        reset_i;
    logic        v_i;
    div_req_t    req_i;
    logic        ready_and_o;
    logic        v_o;
    div_resp_t   resp_o;
    logic        yumi_i;
    row_t        rows [n_rows];
    int          err_cnt;
    int unsigned cycle_cnt;
    logic [31:0] seed;

    idiv_top DUT (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .v_i         (v_i),
        .req_i       (req_i),
        .ready_and_o (ready_and_o),
        .v_o         (v_o),
        .resp_o      (resp_o),
        .yumi_i      (yumi_i)
    );

    bind idiv_controller idiv_assertions u_assertions (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .ready_i (ready_and_o),
        .valid_i (v_o),
        .yumi_i  (yumi_i),
        .state_i (state_r),
        .ctrl_i  (ctrl_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ========================================
    // reference model and table
    // ========================================
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // truncating division, remainder takes the dividend's sign
    function automatic div_resp_t ref_div(input div_req_t rq);
        div_resp_t    rs;
        logic         a_neg;
        logic         b_neg;
        logic [w-1:0] a_mag;
        logic [w-1:0] b_mag;
        a_neg = rq.is_signed & rq.dividend[w-1];
        b_neg = rq.is_signed & rq.divisor[w-1];
        a_mag = a_neg ? -rq.dividend : rq.dividend;
        b_mag = b_neg ? -rq.divisor : rq.divisor;
        if (rq.divisor == '0) begin
            rs.quotient  = ones;
            rs.remainder = rq.dividend;
        end else begin
            rs.quotient  = (a_neg ^ b_neg) ? -(a_mag / b_mag) : (a_mag / b_mag);
            rs.remainder = a_neg ? -(a_mag % b_mag) : (a_mag % b_mag);
        end
        return rs;
    endfunction

    function automatic row_t make_row(input logic [w-1:0] a, input logic [w-1:0] b,
                                      input logic sgn, input logic [1:0] dly,
                                      input logic [w-1:0] q, input logic [w-1:0] r);
        row_t rw;
        rw.req   = '{dividend: a, divisor: b, is_signed: sgn};
        rw.delay = dly;
        rw.exp   = '{quotient: q, remainder: r};
        return rw;
    endfunction

    task automatic fill_table();
        div_req_t rq;
        rows[0]  = make_row(100, 7, 1'b0, 2'd0, 14, 2);
        rows[1]  = make_row(ones, 3, 1'b0, 2'd1, third, 0);
        rows[2]  = make_row(5, 9, 1'b0, 2'd3, 0, 5);
        rows[3]  = make_row(0, 5, 1'b0, 2'd0, 0, 0);
        rows[4]  = make_row(100, 7, 1'b1, 2'd0, 14, 2);
        rows[5]  = make_row(-100, 7, 1'b1, 2'd2, -14, -2);
        rows[6]  = make_row(100, -7, 1'b1, 2'd0, -14, 2);
        rows[7]  = make_row(-100, -7, 1'b1, 2'd1, 14, -2);
        rows[8]  = make_row(55, 0, 1'b0, 2'd0, ones, 55);
        rows[9]  = make_row(-55, 0, 1'b1, 2'd2, ones, -55);
        rows[10] = make_row(min_v, -1, 1'b1, 2'd3, min_v, 0);
        rows[11] = make_row(min_v, ones, 1'b0, 2'd0, 0, min_v);
        for (int i = n_fixed; i < n_rows; i++) begin
            seed         = lcg_next(seed);
            rq.dividend  = w'(seed);
            seed         = lcg_next(seed);
            // random shift mixes small and large divisors
            rq.divisor   = w'(seed >> seed[4:0]);
            rq.is_signed = seed[5];
            rows[i].req   = rq;
            rows[i].delay = seed[7:6];
            rows[i].exp   = ref_div(rq);
        end
    endtask

    // ========================================
    // checks and row sequencing
    // ========================================
    task automatic check_resp(input string what, input div_resp_t got, input div_resp_t exp);
        if (got.quotient !== exp.quotient) begin
            $display("MISMATCH at %0t: %s quotient %h, expected %h",
                     $time, what, got.quotient, exp.quotient);
            err_cnt++;
        end
        if (got.remainder !== exp.remainder) begin
            $display("MISMATCH at %0t: %s remainder %h, expected %h",
                     $time, what, got.remainder, exp.remainder);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // inputs change and outputs are sampled just after the rising edge
    task automatic tick();
        @(posedge clk_i);
        #1;
    endtask

    task automatic run_row(input int idx);
        div_resp_t held;
        int        lat;
        int        err_before;
        err_before = err_cnt;
        while (!ready_and_o) begin
            tick();
        end
        tick();
        lat = 1;
        while (!v_o) begin
            tick();
            lat++;
        end
        if (lat < `IDIV_ITERS + 5 || lat > `IDIV_ITERS + 8) begin
            $display("row %0d: result came %0d cycles after accept, outside the allowed range",
                     idx, lat);
            err_cnt++;
        end
        check_bit("ready_and_o with v_o", ready_and_o, 1'b0);
        held = resp_o;
        repeat (rows[idx].delay) begin
            tick();
            check_bit("v_o under back-pressure", v_o, 1'b1);
            check_bit("ready_and_o under back-pressure", ready_and_o, 1'b0);
            check_resp("held resp_o", resp_o, held);
        end
        check_resp($sformatf("row %0d", idx), resp_o, rows[idx].exp);
        if (!rows[idx].req.is_signed && rows[idx].req.divisor != '0) begin
            check_bit("remainder below divisor", resp_o.remainder < rows[idx].req.divisor, 1'b1);
        end
        // v_i stays high so the next request follows right away
        yumi_i = 1'b1;
        if (idx + 1 < n_rows) begin
            req_i = rows[idx + 1].req;
        end else begin
            v_i = 1'b0;
        end
        tick();
        yumi_i = 1'b0;
        check_bit("ready_and_o after yumi_i", ready_and_o, 1'b1);
        $display("row %0d: %h / %h signed %b -> q %h r %h, latency %0d, %s",
                 idx, rows[idx].req.dividend, rows[idx].req.divisor, rows[idx].req.is_signed,
                 held.quotient, held.remainder, lat, (err_cnt == err_before) ? "ok" : "FAILED");
    endtask

    initial begin
        reset_i = 1'b1;
        v_i     = 1'b0;
        req_i   = '0;
        yumi_i  = 1'b0;
        err_cnt = 0;
        seed    = 32'd2525;
        fill_table();
        repeat (reset_cycles) begin
            tick();
        end
        reset_i = 1'b0;
        check_bit("ready_and_o after reset", ready_and_o, 1'b1);
        check_bit("v_o after reset", v_o, 1'b0);
        req_i = rows[0].req;
        v_i   = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            run_row(i);
        end
        $display("rows run %0d, errors %0d", n_rows, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // ends a hung run
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Errors found");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
verilog/idiv_pkg.sv
verilog/idiv_controller.sv
verilog/idiv_datapath.sv
verilog/idiv_top.sv
testbench/idiv_assertions.sv
testbench/idiv_tb.sv

//--- Makefile
# Verilator build and run of the iterative divider testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, pass if sim.log holds the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module idiv_tb -Mdir obj_dir -o idiv_sim
	./obj_dir/idiv_sim | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
